// ==== design/fm_ctrl_pkg.sv ====
/*
 * Shared register map, counter lengths and payload types for the FM timer
 * control block. Modules take it with a wildcard import in their header.
 */
package fm_ctrl_pkg;

    // Timer register map
    localparam logic [7:0] REG_TIMER_A_HI = 8'h24;
    localparam logic [7:0] REG_TIMER_A_LO = 8'h25;
    localparam logic [7:0] REG_TIMER_B    = 8'h26;
    localparam logic [7:0] REG_TIMER_CTL  = 8'h27;

    // Prescaler select registers ignore the data byte
    localparam logic [7:0] REG_DIV6 = 8'h2D;
    localparam logic [7:0] REG_DIV3 = 8'h2E;
    localparam logic [7:0] REG_DIV2 = 8'h2F;

    // External enables per internal enable
    localparam int DIV6_COUNT = 6;
    localparam int DIV3_COUNT = 3;
    localparam int DIV2_COUNT = 2;

    localparam int FRAME_SLOTS = 24;   // Internal enables per frame pulse
    localparam int TIMER_B_DIV = 16;   // Frame pulses per timer B tick
    localparam int BUSY_SLOTS  = 32;   // Internal enables of busy after a data write

    // Counter widths
    localparam int DIV_CNT_W = $clog2(DIV6_COUNT);
    localparam int FRAME_W   = $clog2(FRAME_SLOTS);
    localparam int TB_DIV_W  = $clog2(TIMER_B_DIV);
    localparam int BUSY_W    = $clog2(BUSY_SLOTS);

    typedef enum logic [1:0] {
        DIV6 = 2'd0,
        DIV3 = 2'd1,
        DIV2 = 2'd2
    } div_sel_t;

    typedef logic [9:0] timer_a_t;
    typedef logic [7:0] timer_b_t;

    // Timer setup as held in the register file
    typedef struct packed {
        timer_a_t value_a;
        timer_b_t value_b;
        logic     load_a;
        logic     load_b;
        logic     irq_en_a;
        logic     irq_en_b;
    } timer_cfg_t;

    // Flag clears, one cycle each
    typedef struct packed {
        logic clr_a;
        logic clr_b;
    } timer_clr_t;

    // One register write from the CPU side
    typedef struct packed {
        logic       strobe;
        logic [7:0] addr;
        logic [7:0] data;
    } reg_wr_t;

endpackage

// ==== design/fm_clkgen.sv ====
/*
 * Prescaler and frame timing. Divides the external enable into the
 * internal enable and derives the timer A and timer B ticks from it.
 */
`timescale 1ns/1ps

module fm_clkgen import fm_ctrl_pkg::*; (
    input  logic     zero,
    input  logic     rst,
    input  logic     cen,
    input  div_sel_t div_sel,
    output logic     clk_en,
    output logic     tick_a,
    output logic     tick_b
);

    logic [DIV_CNT_W-1:0] div_cnt;
    logic [DIV_CNT_W-1:0] div_last;
    div_sel_t             div_sel_q;    // Previous select, to spot a change
    logic                 div_change;
    logic [FRAME_W-1:0]   frame_cnt;
    logic [TB_DIV_W-1:0]  frame_b_cnt;
    logic                 frame_end;

    always_comb begin
        case (div_sel)
            DIV3:    div_last = DIV_CNT_W'(DIV3_COUNT - 1);
            DIV2:    div_last = DIV_CNT_W'(DIV2_COUNT - 1);
            default: div_last = DIV_CNT_W'(DIV6_COUNT - 1);
        endcase
    end

    assign div_change = (div_sel != div_sel_q);

    // Prescaler restarts whenever the select moves
    always_ff @(posedge zero) begin
        if (rst) begin
            div_cnt   <= '0;
            div_sel_q <= DIV6;
        end else begin
            div_sel_q <= div_sel;
            if (div_change) begin
                div_cnt <= '0;
            end else if (cen) begin
                div_cnt <= (div_cnt == div_last) ? '0 : div_cnt + 1'b1;
            end
        end
    end

    assign clk_en    = cen && !div_change && (div_cnt == div_last);
    assign frame_end = clk_en && (frame_cnt == FRAME_W'(FRAME_SLOTS - 1));

    // Frame slots and the 16 frame divider for timer B
    always_ff @(posedge zero) begin
        if (rst) begin
            frame_cnt   <= '0;
            frame_b_cnt <= '0;
            tick_a      <= 1'b0;
            tick_b      <= 1'b0;
        end else begin
            tick_a <= frame_end;
            tick_b <= frame_end && (frame_b_cnt == TB_DIV_W'(TIMER_B_DIV - 1));
            if (clk_en) begin
                frame_cnt <= frame_end ? '0 : frame_cnt + 1'b1;
            end
            if (frame_end) begin
                frame_b_cnt <= frame_b_cnt + 1'b1;   // Wraps at 16
            end
        end
    end

    // Timer B only ever ticks together with timer A
    a_tick_b_with_a: assert property (@(posedge zero) disable iff (rst) tick_b |-> tick_a);

endmodule

// ==== design/fm_bus.sv ====
/*
 * CPU side of the chip. Decodes address and data writes into register
 * write strobes, runs the busy countdown and returns the status byte.
 */
`timescale 1ns/1ps

module fm_bus import fm_ctrl_pkg::*; (
    input  logic       zero,
    input  logic       rst,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    input  logic       clk_en,
    input  logic       flag_a,
    input  logic       flag_b,
    output reg_wr_t    reg_wr,
    output logic [7:0] dout,
    output logic       irq_n
);

    logic              write;
    logic              data_wr;
    logic [7:0]        addr_q;     // Register address from the last address write
    logic              busy;
    logic [BUSY_W-1:0] busy_cnt;

    assign write   = !cs_n && !wr_n;
    assign data_wr = write && addr[0];

    always_ff @(posedge zero) begin
        if (rst) begin
            addr_q <= '0;
        end else if (write && !addr[0]) begin
            addr_q <= din;
        end
    end

    // Data write goes out in the same cycle
    assign reg_wr = '{strobe: data_wr, addr: addr_q, data: din};

    // Busy countdown in internal enables
    always_ff @(posedge zero) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;          // Restarts on every data write
            busy_cnt <= '0;
        end else if (busy && clk_en) begin
            if (busy_cnt == BUSY_W'(BUSY_SLOTS - 1)) begin
                busy <= 1'b0;
            end
            busy_cnt <= busy_cnt + 1'b1;
        end
    end

    // Status byte
    always_ff @(posedge zero) begin
        if (rst) begin
            dout <= '0;
        end else begin
            dout <= {busy, 5'b0, flag_b, flag_a};
        end
    end

    assign irq_n = !(flag_a || flag_b);

    a_idle_after_rst: assert property (@(posedge zero) rst |=> !busy);

endmodule

// ==== design/fm_regs.sv ====
/*
 * Register file for the timer and prescaler registers. Takes the write
 * strobes from the bus and holds the timer setup, flag clears and the
 * prescaler select, all valid one cycle after the write.
 */
`timescale 1ns/1ps

module fm_regs import fm_ctrl_pkg::*; (
    input  logic       zero,
    input  logic       rst,
    input  reg_wr_t    reg_wr,
    output timer_cfg_t cfg,
    output timer_clr_t clr,
    output div_sel_t   div_sel
);

    timer_a_t value_a;
    timer_b_t value_b;
    logic     load_a;
    logic     load_b;
    logic     irq_en_a;
    logic     irq_en_b;

    // Timer periods
    always_ff @(posedge zero) begin
        if (reg_wr.strobe) begin
            case (reg_wr.addr)
                REG_TIMER_A_HI: value_a[9:2] <= reg_wr.data;
                REG_TIMER_A_LO: value_a[1:0] <= reg_wr.data[1:0];
                REG_TIMER_B:    value_b      <= reg_wr.data;
                default: ;
            endcase
        end
    end

    // Control levels, clear strobes and prescaler
    always_ff @(posedge zero) begin
        if (rst) begin
            load_a   <= 1'b0;
            load_b   <= 1'b0;
            irq_en_a <= 1'b0;
            irq_en_b <= 1'b0;
            clr      <= '0;
            div_sel  <= DIV6;
        end else begin
            clr <= '0;   // Strobes last one cycle
            if (reg_wr.strobe) begin
                case (reg_wr.addr)
                    REG_TIMER_CTL: begin
                        load_a    <= reg_wr.data[0];
                        load_b    <= reg_wr.data[1];
                        irq_en_a  <= reg_wr.data[2];
                        irq_en_b  <= reg_wr.data[3];
                        clr.clr_a <= reg_wr.data[4];
                        clr.clr_b <= reg_wr.data[5];
                    end
                    REG_DIV6: div_sel <= DIV6;
                    REG_DIV3: div_sel <= DIV3;
                    REG_DIV2: div_sel <= DIV2;
                    default: ;
                endcase
            end
        end
    end

    assign cfg = '{
        value_a:  value_a,
        value_b:  value_b,
        load_a:   load_a,
        load_b:   load_b,
        irq_en_a: irq_en_a,
        irq_en_b: irq_en_b
    };

    // A clear never stretches past one cycle
    a_clr_single: assert property (@(posedge zero) disable iff (rst) (|clr) |=> !(|clr));

endmodule

// ==== design/fm_timer.sv ====
/*
 * Reloading up-counter with an overflow flag, used for both FM timers.
 * The count width comes from the count_t type parameter.
 */
`timescale 1ns/1ps

module fm_timer #(
    parameter type count_t = logic [7:0]
) (
    input  logic   zero,
    input  logic   rst,
    input  logic   tick,
    input  count_t value,
    input  logic   load,
    input  logic   irq_en,
    input  logic   clr,
    output logic   flag
);

    count_t cnt;
    logic   running;    // A tick has been seen since load went high
    logic   overflow;

    assign overflow = tick && load && running && (cnt == '1);

    always_ff @(posedge zero) begin
        if (rst) begin
            cnt     <= '0;
            running <= 1'b0;
        end else if (!load) begin
            cnt     <= value;          // Held at the period while stopped
            running <= 1'b0;
        end else if (tick) begin
            running <= 1'b1;
            if (!running || overflow) begin
                cnt <= value;          // First tick after load, or wrap
            end else begin
                cnt <= cnt + count_t'(1);
            end
        end
    end

    always_ff @(posedge zero) begin
        if (rst) begin
            flag <= 1'b0;
        end else if (clr) begin
            flag <= 1'b0;              // Clear wins over overflow
        end else if (overflow && irq_en) begin
            flag <= 1'b1;
        end
    end

    a_flag_needs_irq: assert property (
        @(posedge zero) disable iff (rst) $rose(flag) |-> $past(irq_en)
    );

endmodule

// ==== design/fm_ctrl_top.sv ====
/*
 * Control side of the FM chip: CPU bus, timer registers, prescaler and
 * the two timers. Drive cen at 1 to run the prescaler from every clock.
 */
`timescale 1ns/1ps

module fm_ctrl_top import fm_ctrl_pkg::*; (
    input  logic       zero,
    input  logic       rst,
    input  logic       cen,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output logic [7:0] dout,
    output logic       irq_n,
    output logic [7:0] debug_view
);

    reg_wr_t    reg_wr;
    timer_cfg_t cfg;
    timer_clr_t clr;
    div_sel_t   div_sel;
    logic       clk_en;
    logic       tick_a;
    logic       tick_b;
    logic       flag_a;
    logic       flag_b;

    assign debug_view = {4'b0, flag_b, flag_a, div_sel};

    fm_bus u_bus (
        .zero   (zero),
        .rst    (rst),
        .din    (din),
        .addr   (addr),
        .cs_n   (cs_n),
        .wr_n   (wr_n),
        .clk_en (clk_en),
        .flag_a (flag_a),
        .flag_b (flag_b),
        .reg_wr (reg_wr),
        .dout   (dout),
        .irq_n  (irq_n)
    );

    fm_regs u_regs (
        .zero    (zero),
        .rst     (rst),
        .reg_wr  (reg_wr),
        .cfg     (cfg),
        .clr     (clr),
        .div_sel (div_sel)
    );

    fm_clkgen u_clkgen (
        .zero    (zero),
        .rst     (rst),
        .cen     (cen),
        .div_sel (div_sel),
        .clk_en  (clk_en),
        .tick_a  (tick_a),
        .tick_b  (tick_b)
    );

    fm_timer #(.count_t(timer_a_t)) u_timer_a (
        .zero   (zero),
        .rst    (rst),
        .tick   (tick_a),
        .value  (cfg.value_a),
        .load   (cfg.load_a),
        .irq_en (cfg.irq_en_a),
        .clr    (clr.clr_a),
        .flag   (flag_a)
    );

    fm_timer #(.count_t(timer_b_t)) u_timer_b (
        .zero   (zero),
        .rst    (rst),
        .tick   (tick_b),
        .value  (cfg.value_b),
        .load   (cfg.load_b),
        .irq_en (cfg.irq_en_b),
        .clr    (clr.clr_b),
        .flag   (flag_b)
    );

endmodule

// ==== testbench/tb_fm_ctrl.sv ====
/*
 * Testbench for the FM control block. Programs timers and prescaler with
 * random values from a fixed seed and checks status, irq_n and debug_view
 * against a cycle-window model of the timers.
 */
`timescale 1ns/1ps

module tb_fm_ctrl
    import fm_ctrl_pkg::*;
();

    logic       zero;
    logic       rst;
    logic       cen;
    logic [7:0] din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    logic [7:0] dout;
    logic       irq_n;
    logic [7:0] debug_view;

    integer   seed;
    int       errors;
    int       timeouts;
    int       cur_div;     // Model of the prescaler ratio
    int       n;
    int       limit;
    int       cycles;
    bit       leaked;
    timer_a_t value_a;
    timer_b_t value_b;
    logic [7:0] sel_reg;

    fm_ctrl_top dut (
        .zero       (zero),
        .rst        (rst),
        .cen        (cen),
        .din        (din),
        .addr       (addr),
        .cs_n       (cs_n),
        .wr_n       (wr_n),
        .dout       (dout),
        .irq_n      (irq_n),
        .debug_view (debug_view)
    );

    initial begin
        zero = 1'b0;
        forever #10 zero = ~zero;
    end

    // Advance one clock and settle 2 ns past the edge
    task automatic step();
        @(posedge zero);
        #2;
    endtask

    // Address write followed by the data write
    task automatic bus_write(input logic [7:0] reg_addr, input logic [7:0] data);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = 2'd0;
        din  = reg_addr;
        step();
        addr = 2'd1;
        din  = data;
        step();
        cs_n = 1'b1;
        wr_n = 1'b1;
        addr = 2'd0;
        din  = 8'h00;
    endtask

    task automatic report_mismatch(input string name, input int exp, input int act);
        errors++;
        $display("Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
    endtask

    task automatic wait_dout_bit(input string name, input int idx, input logic level,
                                 input int max_cycles, output int waited);
        waited = 0;
        while (dout[idx] !== level && waited < max_cycles) begin
            step();
            waited++;
        end
        if (dout[idx] !== level) begin
            timeouts++;
            $display("Timeout: %s, status bit %0d never reached %0b in %0d cycles",
                     name, idx, level, max_cycles);
        end
    endtask

    // Flag window of n tick periods plus one period of load alignment
    task automatic check_timer_flag(input string name, input int flag_bit,
                                    input int ticks, input int period);
        int  min_c;
        int  max_c;
        int  count;
        bit  seen;
        min_c = ticks * period;
        max_c = (ticks + 1) * period + 4;
        count = 0;
        seen  = 1'b0;
        while (!seen && count < max_c) begin
            step();
            count++;
            if (dout[flag_bit] === 1'b1) begin
                seen = 1'b1;
            end else if (irq_n !== 1'b1 && count < min_c) begin
                report_mismatch({name, "_irq_early"}, 1, irq_n);
            end
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout: %s flag did not set within %0d cycles", name, max_c);
        end else begin
            if (count < min_c) begin
                errors++;
                $display("Error: %s expected flag after %0d..%0d cycles actual %0d",
                         name, min_c, max_c, count);
            end
            if (irq_n !== 1'b0) report_mismatch({name, "_irq_n"}, 0, irq_n);
        end
    endtask

    // Clear both flags with the timers stopped and let busy run out
    task automatic clear_flags(input string name);
        int waited;
        bus_write(REG_TIMER_CTL, 8'h30);
        step();
        step();
        if (irq_n !== 1'b1) report_mismatch({name, "_clr_irq_n"}, 1, irq_n);
        if (dout[1:0] !== 2'b00) report_mismatch({name, "_clr_flags"}, 0, dout[1:0]);
        wait_dout_bit({name, "_clr_busy"}, 7, 1'b0, BUSY_SLOTS * 6 + 8, waited);
        if (dout !== 8'h00) report_mismatch({name, "_clr_dout"}, 0, dout);
    endtask

    function automatic logic [1:0] div_code(input logic [7:0] reg_addr);
        case (reg_addr)
            8'h2E:   return 2'd1;
            8'h2F:   return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

    function automatic int div_ratio(input logic [7:0] reg_addr);
        case (reg_addr)
            8'h2E:   return 3;
            8'h2F:   return 2;
            default: return 6;
        endcase
    endfunction

    initial begin
        seed     = 32'ha4f1e047;
        errors   = 0;
        timeouts = 0;
        cur_div  = 6;
        rst  = 1'b1;
        cen  = 1'b1;
        din  = 8'h00;
        addr = 2'd0;
        cs_n = 1'b1;
        wr_n = 1'b1;
        repeat (5) @(posedge zero);
        #2;
        rst = 1'b0;
        step();

        // Reset state
        if (dout !== 8'h00) report_mismatch("reset_dout", 8'h00, dout);
        if (irq_n !== 1'b1) report_mismatch("reset_irq_n", 1, irq_n);
        if (debug_view !== 8'h00) report_mismatch("reset_debug_view", 8'h00, debug_view);

        // Busy after a data write
        bus_write(REG_TIMER_B, 8'($random(seed)));
        wait_dout_bit("busy_rise", 7, 1'b1, 4, cycles);
        wait_dout_bit("busy_fall", 7, 1'b0, BUSY_SLOTS * 6 + 8, cycles);

        // Timer A near the top of its range
        n       = 1 + int'($unsigned($random(seed)) % 4);
        value_a = 10'(1024 - n);
        bus_write(REG_TIMER_A_HI, value_a[9:2]);
        bus_write(REG_TIMER_A_LO, {6'b0, value_a[1:0]});
        bus_write(REG_TIMER_CTL, 8'h05);
        check_timer_flag("timer_a", 0, n, FRAME_SLOTS * cur_div);
        if (debug_view[2] !== 1'b1) report_mismatch("timer_a_debug_flag", 1, debug_view[2]);
        clear_flags("timer_a");

        // Timer B at divide by 2
        bus_write(REG_DIV2, 8'h00);
        step();
        cur_div = div_ratio(REG_DIV2);
        if (debug_view[1:0] !== div_code(REG_DIV2)) begin
            report_mismatch("timer_b_div", div_code(REG_DIV2), debug_view[1:0]);
        end
        n       = 1 + int'($unsigned($random(seed)) % 3);
        value_b = 8'(256 - n);
        bus_write(REG_TIMER_B, value_b);
        bus_write(REG_TIMER_CTL, 8'h0A);
        check_timer_flag("timer_b", 1, n, TIMER_B_DIV * FRAME_SLOTS * cur_div);
        if (debug_view[3] !== 1'b1) report_mismatch("timer_b_debug_flag", 1, debug_view[3]);
        clear_flags("timer_b");

        // Running timer with its interrupt masked
        n       = 1 + int'($unsigned($random(seed)) % 4);
        value_a = 10'(1024 - n);
        bus_write(REG_TIMER_A_HI, value_a[9:2]);
        bus_write(REG_TIMER_A_LO, {6'b0, value_a[1:0]});
        bus_write(REG_TIMER_CTL, 8'h01);
        limit  = 2 * (n + 1) * FRAME_SLOTS * cur_div;
        leaked = 1'b0;
        for (int i = 0; i < limit; i++) begin
            step();
            if (!leaked && (irq_n !== 1'b1 || dout[1:0] !== 2'b00)) begin
                leaked = 1'b1;
                report_mismatch("masked_irq_n", 1, irq_n);
            end
        end
        bus_write(REG_TIMER_CTL, 8'h00);

        // Prescaler select in random order
        for (int i = 0; i < 8; i++) begin
            case ($unsigned($random(seed)) % 3)
                0:       sel_reg = REG_DIV3;
                1:       sel_reg = REG_DIV6;
                default: sel_reg = REG_DIV2;
            endcase
            bus_write(sel_reg, 8'($random(seed)));
            step();
            if (debug_view[1:0] !== div_code(sel_reg)) begin
                report_mismatch("div_select", div_code(sel_reg), debug_view[1:0]);
            end
        end

        $display("Errors: %0d  Timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
design/fm_ctrl_pkg.sv
design/fm_clkgen.sv
design/fm_bus.sv
design/fm_regs.sv
design/fm_timer.sv
design/fm_ctrl_top.sv
testbench/tb_fm_ctrl.sv

// ==== Makefile ====
# Verilator build and run of the FM control block testbench

VERILATOR ?= verilator
TOP       ?= tb_fm_ctrl
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Simulation completed successfully$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
